//--- Makefile
VERILATOR ?= verilator
TOP       ?= mipsExcept_tb
FILELIST  ?= mipsExcept.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cp0Regs.sv
`timescale 1ns/10ps
`include "mipsExcept_macros.svh"

module cp0Regs import mipsExceptPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic [5:0]       hwInt,
    input  logic             excCommit,
    input  logic             eretCommit,
    input  excCodeT          excCode,
    input  logic             badAddrValid,
    input  logic             badAddrFromPc,
    input  logic [`XLEN-1:0] memPc,
    input  logic [`XLEN-1:0] memAddr,
    input  logic             mtc0Commit,
    input  logic [4:0]       cp0WrAddr,
    input  logic [`XLEN-1:0] cp0WrData,
    input  logic [4:0]       cp0RdAddr,
    output logic [`XLEN-1:0] cp0Status,
    output logic [`XLEN-1:0] cp0Cause,
    output logic [`XLEN-1:0] cp0RdData,
    output logic [`XLEN-1:0] redirectPc
);

    localparam int StatusExlBit = 1;

    // BEV, IM, EXL and IE are software writable
    localparam logic [`XLEN-1:0] StatusWrMask = 32'h0040_FF03;

    logic [`XLEN-1:0] status;
    logic [`XLEN-1:0] cause;
    logic [`XLEN-1:0] epc;
    logic [`XLEN-1:0] badVAddr;
    logic             wrStatus;
    logic             wrCause;
    logic             wrEpc;

    // mtc0 only lands when no exception or eret commits
    assign wrStatus = mtc0Commit && !excCommit && !eretCommit && (cp0WrAddr == `CP0_STATUS);
    assign wrCause  = mtc0Commit && !excCommit && !eretCommit && (cp0WrAddr == `CP0_CAUSE);
    assign wrEpc    = mtc0Commit && !excCommit && !eretCommit && (cp0WrAddr == `CP0_EPC);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            status <= `STATUS_RESET;
        end else if (excCommit) begin
            status[StatusExlBit] <= 1'b1;
        end else if (eretCommit) begin
            status[StatusExlBit] <= 1'b0;
        end else if (wrStatus) begin
            status <= (status & ~StatusWrMask) | (cp0WrData & StatusWrMask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cause <= '0;
        end else begin
            cause[15:10] <= hwInt;              // hardware lines sampled every cycle
            if (excCommit) begin
                cause[6:2] <= excCode;
            end else if (wrCause) begin
                cause[9:8] <= cp0WrData[9:8];   // software interrupt bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epc <= '0;
        end else if (excCommit) begin
            epc <= memPc;
        end else if (wrEpc) begin
            epc <= cp0WrData;
        end
    end

    // read only from software
    always_ff @(posedge clk) begin
        if (!rstN) begin
            badVAddr <= '0;
        end else if (excCommit && badAddrValid) begin
            badVAddr <= badAddrFromPc ? memPc : memAddr;
        end
    end

    always_comb begin
        case (cp0RdAddr)
            `CP0_STATUS:   cp0RdData = status;
            `CP0_CAUSE:    cp0RdData = cause;
            `CP0_EPC:      cp0RdData = epc;
            `CP0_BADVADDR: cp0RdData = badVAddr;
            default:       cp0RdData = '0;
        endcase
    end

    assign cp0Status  = status;
    assign cp0Cause   = cause;
    assign redirectPc = eretCommit ? epc : `EXC_VECTOR;  // return address or handler

endmodule

//--- exceptDetect.sv
`timescale 1ns/10ps
`include "mipsExcept_macros.svh"

module exceptDetect import mipsExceptPkg::*; (
    input  logic             memValid,
    input  logic             memStall,
    input  exceptVecT        memExcept,
    input  logic [`XLEN-1:0] memPc,
    input  logic [`XLEN-1:0] cp0Status,
    input  logic [`XLEN-1:0] cp0Cause,
    input  regsWrT           memRegsWr,
    input  logic             memMtc0,
    output regsWrT           memRegsWrFinal,
    output logic             idFlush,
    output logic             exeFlush,
    output logic             memFlush,
    output redirectT         redirect,
    output logic             excCommit,
    output logic             eretCommit,
    output excCodeT          excCode,
    output logic             badAddrFromPc,
    output logic             badAddrValid,
    output logic             mtc0Commit
);

    exceptVecT merged;
    logic      active;
    logic      intPending;
    logic      anyExc;
    logic      addrFault;
    logic      flushAll;

    assign active = memValid && !memStall;  // nothing leaves the stage while stalled

    // IP & IM overlap, IE on, EXL off
    assign intPending = (|(cp0Cause[15:8] & cp0Status[15:8])) && cp0Status[0] && !cp0Status[1];

    always_comb begin
        merged              = memExcept;
        merged.interrupt    = memExcept.interrupt | intPending;
        merged.fetchAddrErr = memExcept.fetchAddrErr | (memPc[1:0] != 2'b00);
    end

    assign anyExc = merged.interrupt | merged.fetchAddrErr | merged.reservedInstr |
                    merged.overflow | merged.syscall | merged.breakpoint |
                    merged.loadAddrErr | merged.storeAddrErr;

    // highest cause wins
    always_comb begin
        excCode       = excInt;
        addrFault     = 1'b0;
        badAddrFromPc = 1'b0;
        if (merged.interrupt) begin
            excCode = excInt;
        end else if (merged.fetchAddrErr) begin
            excCode       = excAdEL;
            addrFault     = 1'b1;
            badAddrFromPc = 1'b1;           // bad address is the PC itself
        end else if (merged.reservedInstr) begin
            excCode = excRI;
        end else if (merged.overflow) begin
            excCode = excOv;
        end else if (merged.syscall) begin
            excCode = excSys;
        end else if (merged.breakpoint) begin
            excCode = excBp;
        end else if (merged.loadAddrErr) begin
            excCode   = excAdEL;
            addrFault = 1'b1;
        end else if (merged.storeAddrErr) begin
            excCode   = excAdES;
            addrFault = 1'b1;
        end
    end

    assign excCommit    = active && anyExc;
    assign eretCommit   = active && !anyExc && merged.eret;  // a fault hides the eret
    assign badAddrValid = excCommit && addrFault;
    assign mtc0Commit   = active && memMtc0 && !anyExc;

    assign flushAll = excCommit || eretCommit;
    assign idFlush  = flushAll;
    assign exeFlush = flushAll;
    assign memFlush = flushAll;

    always_comb begin
        if (excCommit) begin
            redirect = redirException;
        end else if (eretCommit) begin
            redirect = redirEret;
        end else begin
            redirect = redirNone;
        end
    end

    // write survives only for a live, clean instruction
    always_comb begin
        memRegsWrFinal      = memRegsWr;
        memRegsWrFinal.wrEn = memRegsWr.wrEn && active && !flushAll;
    end

endmodule

//--- mipsExcept.f
+incdir+.
mipsExceptPkg.sv
stageReg.sv
exceptDetect.sv
cp0Regs.sv
mipsExceptTop.sv
mipsExcept_properties.sv
mipsExcept_tb.sv

//--- mipsExceptPkg.sv
`include "mipsExcept_macros.svh"

package mipsExceptPkg;

    // fault flags collected along the pipe with eret last
    typedef struct packed {
        logic interrupt;
        logic fetchAddrErr;
        logic reservedInstr;
        logic overflow;
        logic syscall;
        logic breakpoint;
        logic loadAddrErr;
        logic storeAddrErr;
        logic eret;
    } exceptVecT;

    typedef struct packed {
        logic             wrEn;
        logic [4:0]       wrAddr;
        logic [`XLEN-1:0] wrData;
    } regsWrT;

    // what the fetch stage has to do next cycle
    typedef enum logic [1:0] {
        redirNone      = 2'd0,
        redirException = 2'd1,
        redirEret      = 2'd2
    } redirectT;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5,
        excSys  = 5'd8,
        excBp   = 5'd9,
        excRI   = 5'd10,
        excOv   = 5'd12
    } excCodeT;

endpackage

//--- mipsExceptTop.sv
`timescale 1ns/10ps
`include "mipsExcept_macros.svh"

module mipsExceptTop import mipsExceptPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exeValid,
    input  logic [`XLEN-1:0] exePc,
    input  logic             exeRi,
    input  logic             exeOverflow,
    input  logic             exeSyscall,
    input  logic             exeBreak,
    input  logic             exeEret,
    input  logic             exeLoadAddrErr,
    input  logic             exeStoreAddrErr,
    input  logic [`XLEN-1:0] exeMemAddr,
    input  logic             exeRegWrEn,
    input  logic [4:0]       exeRegWrAddr,
    input  logic [`XLEN-1:0] exeRegWrData,
    input  logic             exeMtc0,
    input  logic [4:0]       exeCp0Addr,
    input  logic [5:0]       hwInt,
    input  logic             memStall,
    input  logic [4:0]       cp0RdAddr,
    output logic             idFlush,
    output logic             exeFlush,
    output logic             memFlush,
    output redirectT         redirect,
    output logic [`XLEN-1:0] redirectPc,
    output logic             wbValid,
    output logic             wbRegWrEn,
    output logic [4:0]       wbRegWrAddr,
    output logic [`XLEN-1:0] wbRegWrData,
    output logic [`XLEN-1:0] cp0RdData
);

    // PC, data address and mtc0 target for the memory stage
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] memAddr;
        logic             mtc0;
        logic [4:0]       cp0Addr;
    } memInfoT;

    exceptVecT        exeExcept;
    exceptVecT        memExcept;
    regsWrT           exeRegsWr;
    regsWrT           memRegsWr;
    regsWrT           memRegsWrFinal;
    regsWrT           wbRegsWr;
    memInfoT          exeInfo;
    memInfoT          memInfo;
    logic             memValid;
    logic             excCommit;
    logic             eretCommit;
    excCodeT          excCode;
    logic             badAddrFromPc;
    logic             badAddrValid;
    logic             mtc0Commit;
    logic [`XLEN-1:0] cp0Status;
    logic [`XLEN-1:0] cp0Cause;

    assign exeExcept = '{interrupt: 1'b0, fetchAddrErr: 1'b0, reservedInstr: exeRi,
                         overflow: exeOverflow, syscall: exeSyscall, breakpoint: exeBreak,
                         loadAddrErr: exeLoadAddrErr, storeAddrErr: exeStoreAddrErr,
                         eret: exeEret};
    assign exeRegsWr = '{wrEn: exeRegWrEn, wrAddr: exeRegWrAddr, wrData: exeRegWrData};
    assign exeInfo   = '{pc: exePc, memAddr: exeMemAddr, mtc0: exeMtc0, cp0Addr: exeCp0Addr};

    stageReg #(.T(exceptVecT)) exeMemExcept (
        .clk(clk), .rstN(rstN), .stall(memStall), .flush(memFlush),
        .inValid(exeValid), .inData(exeExcept), .outValid(memValid), .outData(memExcept)
    );

    stageReg #(.T(regsWrT)) exeMemRegsWr (
        .clk(clk), .rstN(rstN), .stall(memStall), .flush(memFlush),
        .inValid(exeValid), .inData(exeRegsWr), .outValid(), .outData(memRegsWr)
    );

    stageReg #(.T(memInfoT)) exeMemInfo (
        .clk(clk), .rstN(rstN), .stall(memStall), .flush(memFlush),
        .inValid(exeValid), .inData(exeInfo), .outValid(), .outData(memInfo)
    );

    exceptDetect exceptDetect0 (
        .memValid(memValid), .memStall(memStall), .memExcept(memExcept),
        .memPc(memInfo.pc), .cp0Status(cp0Status), .cp0Cause(cp0Cause),
        .memRegsWr(memRegsWr), .memMtc0(memInfo.mtc0), .memRegsWrFinal(memRegsWrFinal),
        .idFlush(idFlush), .exeFlush(exeFlush), .memFlush(memFlush), .redirect(redirect),
        .excCommit(excCommit), .eretCommit(eretCommit), .excCode(excCode),
        .badAddrFromPc(badAddrFromPc), .badAddrValid(badAddrValid), .mtc0Commit(mtc0Commit)
    );

    cp0Regs cp0Regs0 (
        .clk(clk), .rstN(rstN), .hwInt(hwInt), .excCommit(excCommit),
        .eretCommit(eretCommit), .excCode(excCode), .badAddrValid(badAddrValid),
        .badAddrFromPc(badAddrFromPc), .memPc(memInfo.pc), .memAddr(memInfo.memAddr),
        .mtc0Commit(mtc0Commit), .cp0WrAddr(memInfo.cp0Addr),
        .cp0WrData(memRegsWr.wrData), .cp0RdAddr(cp0RdAddr), .cp0Status(cp0Status),
        .cp0Cause(cp0Cause), .cp0RdData(cp0RdData), .redirectPc(redirectPc)
    );

    // a stall turns into a bubble at writeback
    stageReg #(.T(regsWrT)) memWbRegsWr (
        .clk(clk), .rstN(rstN), .stall(1'b0), .flush(memStall),
        .inValid(memValid), .inData(memRegsWrFinal), .outValid(wbValid), .outData(wbRegsWr)
    );

    assign wbRegWrEn   = wbRegsWr.wrEn;
    assign wbRegWrAddr = wbRegsWr.wrAddr;
    assign wbRegWrData = wbRegsWr.wrData;

endmodule

//--- mipsExcept_macros.svh
`ifndef MIPS_EXCEPT_MACROS_SVH
`define MIPS_EXCEPT_MACROS_SVH

// datapath width
`define XLEN 32

// BEV set, interrupts off, EXL clear, all IM bits masked
`define STATUS_RESET 32'h0040_0000

// general exception entry while BEV is set
`define EXC_VECTOR 32'hBFC0_0380

// CP0 register numbers as seen by mtc0 and mfc0
`define CP0_BADVADDR 5'd8
`define CP0_STATUS 5'd12
`define CP0_CAUSE 5'd13
`define CP0_EPC 5'd14

`endif

//--- mipsExcept_properties.sv
`timescale 1ns/10ps

module mipsExcept_properties import mipsExceptPkg::*; (
    input logic     clk,
    input logic     rstN,
    input logic     memStall,
    input logic     idFlush,
    input logic     exeFlush,
    input logic     memFlush,
    input redirectT redirect,
    input logic     wbValid,
    input logic     wbRegWrEn
);

    // a flush always comes with a new fetch target
    flushHasRedirect: assert property (@(posedge clk) disable iff (!rstN)
        (idFlush || exeFlush || memFlush) |-> (redirect != redirNone))
        else $error("flush raised while redirect is none");

    wbWriteIsValid: assert property (@(posedge clk) disable iff (!rstN)
        wbRegWrEn |-> wbValid)
        else $error("writeback write enable without a valid instruction");

    // held instruction must not act until the stall drops
    noFlushInStall: assert property (@(posedge clk) disable iff (!rstN)
        memStall |-> !(idFlush || exeFlush || memFlush))
        else $error("flush raised during a memory stall");

endmodule

//--- mipsExcept_tb.sv
`timescale 1ns/10ps
`include "mipsExcept_macros.svh"

module mipsExcept_tb import mipsExceptPkg::*; ();

    localparam int ClkPeriod = 20;
    localparam int NumClean = 40;
    localparam int NumMulti = 60;
    localparam int NumStall = 80;
    // reset, reads, clean, single faults, multi faults, interrupt and eret runs, stalls
    localparam int TestCycles = 4 + 12 + NumClean + 7 * 5 + NumMulti + 60 + NumStall * 2;
    localparam int WatchdogNs = TestCycles * ClkPeriod * 3 + 1000;
    localparam logic [31:0] StatusWrMask = 32'h0040_FF03;  // BEV, IM, EXL, IE

    typedef struct packed {
        logic        flush;
        logic [1:0]  redirect;
        logic [31:0] redirectPc;
        logic        wbValid;
        logic        wbEn;
        logic [4:0]  wbAddr;
        logic [31:0] wbData;
        logic [31:0] rdData;
        logic        exc;
        logic        eret;
        logic [4:0]  code;
        logic        badValid;
        logic [31:0] badAddr;
        logic        mtc0Ok;
        logic        wrEnNext;
    } expectT;

    logic        clk;
    logic        rstN;
    logic        exeValid;
    logic [31:0] exePc;
    logic        exeRi;
    logic        exeOverflow;
    logic        exeSyscall;
    logic        exeBreak;
    logic        exeEret;
    logic        exeLoadAddrErr;
    logic        exeStoreAddrErr;
    logic [31:0] exeMemAddr;
    logic        exeRegWrEn;
    logic [4:0]  exeRegWrAddr;
    logic [31:0] exeRegWrData;
    logic        exeMtc0;
    logic [4:0]  exeCp0Addr;
    logic [5:0]  hwInt;
    logic        memStall;
    logic [4:0]  cp0RdAddr;
    logic        idFlush;
    logic        exeFlush;
    logic        memFlush;
    redirectT    redirect;
    logic [31:0] redirectPc;
    logic        wbValid;
    logic        wbRegWrEn;
    logic [4:0]  wbRegWrAddr;
    logic [31:0] wbRegWrData;
    logic [31:0] cp0RdData;

    int          seed;
    logic        stallOn;

    // reference copy of the memory stage, writeback stage and CP0
    logic        mValid;
    logic [31:0] mPc;
    logic [31:0] mAddr;
    logic [31:0] mData;
    logic [6:0]  mFlags;        // ri, ov, sys, bp, adel, ades, eret
    logic        mWrEn;
    logic [4:0]  mWrAddr;
    logic        mMtc0;
    logic [4:0]  mCp0Addr;
    logic        wValid;
    logic        wEn;
    logic [4:0]  wAddr;
    logic [31:0] wData;
    logic [31:0] rStatus;
    logic [31:0] rCause;
    logic [31:0] rEpc;
    logic [31:0] rBadV;

    mipsExceptTop dut0 (
        .clk(clk), .rstN(rstN), .exeValid(exeValid), .exePc(exePc), .exeRi(exeRi),
        .exeOverflow(exeOverflow), .exeSyscall(exeSyscall), .exeBreak(exeBreak),
        .exeEret(exeEret), .exeLoadAddrErr(exeLoadAddrErr),
        .exeStoreAddrErr(exeStoreAddrErr), .exeMemAddr(exeMemAddr),
        .exeRegWrEn(exeRegWrEn), .exeRegWrAddr(exeRegWrAddr), .exeRegWrData(exeRegWrData),
        .exeMtc0(exeMtc0), .exeCp0Addr(exeCp0Addr), .hwInt(hwInt), .memStall(memStall),
        .cp0RdAddr(cp0RdAddr), .idFlush(idFlush), .exeFlush(exeFlush), .memFlush(memFlush),
        .redirect(redirect), .redirectPc(redirectPc), .wbValid(wbValid),
        .wbRegWrEn(wbRegWrEn), .wbRegWrAddr(wbRegWrAddr), .wbRegWrData(wbRegWrData),
        .cp0RdData(cp0RdData)
    );

    bind mipsExceptTop mipsExcept_properties props0 (
        .clk(clk), .rstN(rstN), .memStall(memStall), .idFlush(idFlush),
        .exeFlush(exeFlush), .memFlush(memFlush), .redirect(redirect),
        .wbValid(wbValid), .wbRegWrEn(wbRegWrEn)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogNs);
        $display("Error: watchdog expired at %0t, the test sequence never finished", $time);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch");
        end
    endtask

    // expected outputs of this cycle and what commits at the next edge
    function automatic expectT predict();
        expectT e;
        logic   active;
        logic   intPend;
        logic   fetchErr;
        logic   anyFault;
        e        = '0;
        active   = mValid && !memStall;
        intPend  = (|(rCause[15:8] & rStatus[15:8])) && rStatus[0] && !rStatus[1];
        fetchErr = (mPc[1:0] != 2'b00);
        anyFault = intPend || fetchErr || (|mFlags[6:1]);
        if (intPend) begin
            e.code = excInt;
        end else if (fetchErr) begin
            e.code     = excAdEL;
            e.badValid = 1'b1;
            e.badAddr  = mPc;
        end else if (mFlags[6]) begin
            e.code = excRI;
        end else if (mFlags[5]) begin
            e.code = excOv;
        end else if (mFlags[4]) begin
            e.code = excSys;
        end else if (mFlags[3]) begin
            e.code = excBp;
        end else if (mFlags[2]) begin
            e.code     = excAdEL;
            e.badValid = 1'b1;
            e.badAddr  = mAddr;
        end else if (mFlags[1]) begin
            e.code     = excAdES;
            e.badValid = 1'b1;
            e.badAddr  = mAddr;
        end
        e.exc        = active && anyFault;
        e.eret       = active && !anyFault && mFlags[0];   // fault beats eret
        e.flush      = e.exc || e.eret;
        e.redirect   = e.exc ? redirException : (e.eret ? redirEret : redirNone);
        e.redirectPc = e.eret ? rEpc : `EXC_VECTOR;
        e.mtc0Ok     = active && mMtc0 && !anyFault && !mFlags[0];
        e.wrEnNext   = mWrEn && active && !e.flush;
        e.wbValid    = wValid;
        e.wbEn       = wEn;
        e.wbAddr     = wAddr;
        e.wbData     = wData;
        case (cp0RdAddr)
            `CP0_STATUS:   e.rdData = rStatus;
            `CP0_CAUSE:    e.rdData = rCause;
            `CP0_EPC:      e.rdData = rEpc;
            `CP0_BADVADDR: e.rdData = rBadV;
            default:       e.rdData = '0;
        endcase
        return e;
    endfunction

    task automatic advanceModel(input expectT e);
        if (!rstN) begin
            mValid  = 1'b0;
            wValid  = 1'b0;
            wEn     = 1'b0;
            rStatus = `STATUS_RESET;
            rCause  = '0;
            rEpc    = '0;
            rBadV   = '0;
        end else begin
            wValid = memStall ? 1'b0 : mValid;     // stall leaves a bubble
            wEn    = e.wrEnNext;
            wAddr  = mWrAddr;
            wData  = mData;
            rCause[15:10] = hwInt;
            if (e.exc) begin
                rStatus[1]  = 1'b1;
                rCause[6:2] = e.code;
                rEpc        = mPc;
                if (e.badValid) begin
                    rBadV = e.badAddr;
                end
            end else if (e.eret) begin
                rStatus[1] = 1'b0;
            end else if (e.mtc0Ok) begin
                case (mCp0Addr)
                    `CP0_STATUS: rStatus = (rStatus & ~StatusWrMask) | (mData & StatusWrMask);
                    `CP0_CAUSE:  rCause[9:8] = mData[9:8];
                    `CP0_EPC:    rEpc = mData;
                    default:     ;
                endcase
            end
            if (e.flush) begin
                mValid = 1'b0;
            end else if (!memStall) begin
                mValid = exeValid;
            end
            if (!memStall) begin
                mPc      = exePc;
                mAddr    = exeMemAddr;
                mData    = exeRegWrData;
                mFlags   = {exeRi, exeOverflow, exeSyscall, exeBreak, exeLoadAddrErr,
                            exeStoreAddrErr, exeEret};
                mWrEn    = exeRegWrEn;
                mWrAddr  = exeRegWrAddr;
                mMtc0    = exeMtc0;
                mCp0Addr = exeCp0Addr;
            end
        end
    endtask

    task automatic checkOutputs(input expectT e);
        checkEq("idFlush", {31'b0, idFlush}, {31'b0, e.flush});
        checkEq("exeFlush", {31'b0, exeFlush}, {31'b0, e.flush});
        checkEq("memFlush", {31'b0, memFlush}, {31'b0, e.flush});
        checkEq("redirect", {30'b0, redirect}, {30'b0, e.redirect});
        checkEq("redirectPc", redirectPc, e.redirectPc);
        checkEq("wbValid", {31'b0, wbValid}, {31'b0, e.wbValid});
        checkEq("wbRegWrEn", {31'b0, wbRegWrEn}, {31'b0, e.wbEn});
        if (e.wbEn) begin
            checkEq("wbRegWrAddr", {27'b0, wbRegWrAddr}, {27'b0, e.wbAddr});
            checkEq("wbRegWrData", wbRegWrData, e.wbData);
        end
        checkEq("cp0RdData", cp0RdData, e.rdData);
    endtask

    // check once the falling-edge drive has settled and step the model at the rising edge
    initial begin
        expectT e;
        forever begin
            @(negedge clk);
            #5;
            e = predict();
            if (rstN) begin
                checkOutputs(e);
            end
            @(posedge clk);
            advanceModel(e);
        end
    end

    function automatic logic pickStall();
        logic [31:0] r;
        r = $random(seed);
        return stallOn && r[0];
    endfunction

    function automatic logic [4:0] pickRdAddr();
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    return `CP0_STATUS;
            2'd1:    return `CP0_CAUSE;
            2'd2:    return `CP0_EPC;
            default: return `CP0_BADVADDR;
        endcase
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            exeValid  = 1'b0;
            memStall  = pickStall();
            cp0RdAddr = pickRdAddr();
        end
    endtask

    task automatic readBack();
        logic [4:0] addrs [4];
        addrs = '{`CP0_STATUS, `CP0_CAUSE, `CP0_EPC, `CP0_BADVADDR};
        foreach (addrs[i]) begin
            @(negedge clk);
            exeValid  = 1'b0;
            memStall  = 1'b0;
            cp0RdAddr = addrs[i];
        end
    endtask

    // flags in order ri, ov, sys, bp, adel, ades, eret
    // the instruction stays on the exe inputs until the stage accepts it
    task automatic issue(input logic [6:0] flags, input logic misalign, input logic mtc0,
                         input logic [4:0] cp0Addr, input logic [31:0] data);
        logic [31:0] r;
        @(negedge clk);
        r            = $random(seed);
        exeValid     = 1'b1;
        exePc        = {r[31:2], misalign, 1'b0};
        {exeRi, exeOverflow, exeSyscall, exeBreak, exeLoadAddrErr, exeStoreAddrErr,
         exeEret}    = flags;
        r            = $random(seed);
        exeMemAddr   = r;
        exeMtc0      = mtc0;
        exeCp0Addr   = cp0Addr;
        exeRegWrEn   = !mtc0 && r[0];
        exeRegWrAddr = r[5:1];
        exeRegWrData = mtc0 ? data : $random(seed);
        cp0RdAddr    = pickRdAddr();
        memStall     = pickStall();
        while (memStall) begin
            @(negedge clk);
            memStall = pickStall();
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [6:0]  flags;
        seed = 32'h3e97;
        stallOn = 1'b0;
        rstN = 1'b0;
        exeValid = 1'b0;
        exePc = '0;
        {exeRi, exeOverflow, exeSyscall, exeBreak, exeEret} = '0;
        exeLoadAddrErr = 1'b0;
        exeStoreAddrErr = 1'b0;
        exeMemAddr = '0;
        exeRegWrEn = 1'b0;
        exeRegWrAddr = '0;
        exeRegWrData = '0;
        exeMtc0 = 1'b0;
        exeCp0Addr = '0;
        hwInt = '0;
        memStall = 1'b0;
        cp0RdAddr = '0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;

        readBack();                            // reset values
        repeat (NumClean) issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        idle(4);

        for (int k = 1; k < 7; k++) begin      // one fault at a time
            flags    = '0;
            flags[k] = 1'b1;
            issue(flags, 1'b0, 1'b0, 5'd0, 32'd0);
            readBack();
        end
        issue(7'b0, 1'b1, 1'b0, 5'd0, 32'd0);  // misaligned fetch
        readBack();

        repeat (NumMulti) begin
            r = $random(seed);
            issue(r[6:0], r[7] & r[8], 1'b0, 5'd0, 32'd0);
        end
        idle(4);

        issue(7'b0000001, 1'b0, 1'b0, 5'd0, 32'd0);        // eret clears EXL
        idle(1);
        issue(7'b0, 1'b0, 1'b1, `CP0_STATUS, 32'h0040_FF01);
        idle(2);
        hwInt = 6'b000100;
        idle(2);
        issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // takes Int
        idle(3);
        issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // EXL masks it
        issue(7'b0000001, 1'b0, 1'b0, 5'd0, 32'd0);
        idle(1);
        issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // taken again
        hwInt = 6'b0;
        idle(2);
        issue(7'b0000001, 1'b0, 1'b0, 5'd0, 32'd0);
        idle(1);
        issue(7'b0, 1'b0, 1'b1, `CP0_STATUS, 32'h0040_0001);
        hwInt = 6'h3f;
        idle(2);
        issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // IM all clear
        issue(7'b0, 1'b0, 1'b1, `CP0_STATUS, 32'h0040_FF00);
        idle(2);
        issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // IE clear
        hwInt = 6'b0;
        issue(7'b0, 1'b0, 1'b1, `CP0_CAUSE, 32'h0000_0100);
        issue(7'b0, 1'b0, 1'b1, `CP0_STATUS, 32'h0040_FF01);
        idle(2);
        issue(7'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // software interrupt
        idle(1);
        issue(7'b0, 1'b0, 1'b1, `CP0_CAUSE, 32'h0000_0000);
        issue(7'b0000001, 1'b0, 1'b0, 5'd0, 32'd0);
        idle(1);
        issue(7'b0, 1'b0, 1'b1, `CP0_EPC, 32'h8000_1000);
        issue(7'b0000001, 1'b0, 1'b0, 5'd0, 32'd0);        // return to written EPC
        readBack();

        stallOn = 1'b1;
        repeat (NumStall) begin
            r     = $random(seed);
            flags = (r[3:0] == 4'd0) ? r[10:4] : 7'b0;
            issue(flags, 1'b0, 1'b0, 5'd0, 32'd0);
        end
        stallOn = 1'b0;
        idle(4);

        $display("** PASS **");
        $finish;
    end

endmodule

//--- stageReg.sv
`timescale 1ns/10ps

module stageReg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic flush,
    input  logic inValid,
    input  T     inData,
    output logic outValid,
    output T     outData
);

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            outValid <= 1'b0;           // flush beats stall
        end else if (!stall) begin
            outValid <= inValid;
        end
    end

    // payload moves with the stage and is kept on a flush
    always_ff @(posedge clk) begin
        if (!stall) begin
            outData <= inData;
        end
    end

endmodule
